// ==== src/lc_pkg.sv ====
package lc_pkg;

	// Bus word widths
	localparam int LC_ADDR_W = 8;
	localparam int LC_DATA_W = 32;

	// Register file
	localparam int LC_RF_DATA_W = 24;
	localparam int LC_RF_DEPTH = 16;
	localparam int LC_RF_ADDR_W = 4;

	// Memory
	localparam int LC_MEM_DEPTH = 64;
	localparam int LC_MEM_ADDR_W = 6;

	// Burst length and function field in the low nibble of rx_addr
	localparam int LC_CNT_W = 8;
	localparam int LC_FUNC_W = 4;

	localparam logic [LC_FUNC_W-1:0] FUNC_RF_WR = 4'd0;
	localparam logic [LC_FUNC_W-1:0] FUNC_RF_RD = 4'd1;
	localparam logic [LC_FUNC_W-1:0] FUNC_MEM_WR = 4'd2;
	localparam logic [LC_FUNC_W-1:0] FUNC_MEM_RD = 4'd3;

	localparam logic IO_HOLD = 1'b1;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_DECODE,
		ST_RF_WR,
		ST_MEM_WR,
		ST_ACK,
		ST_RD_FETCH,
		ST_RD_DATA,
		ST_TX,
		ST_TX_DONE
	} lc_state_e;

	// One receive word, seen as a register write or as a read request
	typedef union packed {
		struct packed {
			logic [LC_ADDR_W-1:0] addr;
			logic [LC_RF_DATA_W-1:0] data;
		} rf_wr;
		struct packed {
			logic [LC_ADDR_W-1:0] start;
			logic [LC_CNT_W-1:0] count;
			logic [LC_ADDR_W-1:0] reply_addr;
			logic [7:0] pad;
		} rd_req;
	} lc_rx_word_u;

endpackage

// ==== src/lc_word_counter.sv ====
`timescale 1ns/10ps

module lc_word_counter
	import lc_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 cnt_load,
	input  logic [LC_ADDR_W-1:0] cnt_start,
	input  logic [LC_CNT_W-1:0]  cnt_len,
	input  logic                 cnt_step,
	output logic [LC_ADDR_W-1:0] cnt_addr,
	output logic                 cnt_last
);

	logic [LC_CNT_W-1:0] remain;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt_addr <= '0;
			remain <= '0;
		end
		else if (cnt_load)
		begin
			cnt_addr <= cnt_start;
			remain <= cnt_len;
		end
		else if (cnt_step)
		begin
			// Address wraps at 8 bits
			cnt_addr <= cnt_addr + 1'b1;
			if (remain != '0)
				remain <= remain - 1'b1;
		end
	end

	assign cnt_last = (remain == LC_CNT_W'(1));

endmodule

// ==== src/lc_regfile.sv ====
`timescale 1ns/10ps

module lc_regfile
	import lc_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    rf_load,
	input  logic [LC_ADDR_W-1:0]    rf_addr,
	input  logic [LC_RF_DATA_W-1:0] rf_wdata,
	output logic [LC_RF_DATA_W-1:0] rf_rdata
);

	logic [LC_RF_DATA_W-1:0] regs [LC_RF_DEPTH];
	logic [LC_RF_ADDR_W-1:0] idx;

	assign idx = rf_addr[LC_RF_ADDR_W-1:0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < LC_RF_DEPTH; i++)
				regs[i] <= '0;
		end
		else if (rf_load)
		begin
			regs[idx] <= rf_wdata;
		end
	end

	// Combinational read port
	assign rf_rdata = regs[idx];

endmodule

// ==== src/lc_mem.sv ====
`timescale 1ns/10ps

module lc_mem
	import lc_pkg::*;
(
	input  logic                     clk,
	input  logic                     mem_req,
	input  logic                     mem_write,
	input  logic [LC_MEM_ADDR_W-1:0] mem_addr,
	input  logic [LC_DATA_W-1:0]     mem_wdata,
	output logic [LC_DATA_W-1:0]     mem_rdata
);

	logic [LC_DATA_W-1:0] mem [LC_MEM_DEPTH];

	// Read data lands one cycle after the request
	always_ff @(posedge clk)
	begin
		if (mem_req)
		begin
			if (mem_write)
				mem[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem[mem_addr];
		end
	end

endmodule

// ==== src/lc_isolation.sv ====
`timescale 1ns/10ps

module lc_isolation
	import lc_pkg::*;
(
	input  logic                     lc_isolation,
	input  logic                     rx_ack_lc,
	input  logic [LC_ADDR_W-1:0]     tx_addr_lc,
	input  logic [LC_DATA_W-1:0]     tx_data_lc,
	input  logic                     tx_req_lc,
	input  logic                     tx_pend_lc,
	input  logic                     rf_load_lc,
	input  logic [LC_ADDR_W-1:0]     rf_addr_lc,
	input  logic [LC_RF_DATA_W-1:0]  rf_wdata_lc,
	input  logic                     mem_req_lc,
	input  logic                     mem_write_lc,
	input  logic [LC_MEM_ADDR_W-1:0] mem_addr_lc,
	input  logic [LC_DATA_W-1:0]     mem_wdata_lc,
	output logic                     rx_ack,
	output logic [LC_ADDR_W-1:0]     tx_addr,
	output logic [LC_DATA_W-1:0]     tx_data,
	output logic                     tx_req,
	output logic                     tx_pend,
	output logic                     rf_load,
	output logic [LC_ADDR_W-1:0]     rf_addr,
	output logic [LC_RF_DATA_W-1:0]  rf_wdata,
	output logic                     mem_req,
	output logic                     mem_write,
	output logic [LC_MEM_ADDR_W-1:0] mem_addr,
	output logic [LC_DATA_W-1:0]     mem_wdata
);

	logic hold;

	assign hold = (lc_isolation == IO_HOLD);

	// Bus side
	always_comb
	begin
		if (hold)
		begin
			rx_ack = 1'b0;
			tx_addr = '0;
			tx_data = '0;
			tx_req = 1'b0;
			tx_pend = 1'b0;
		end
		else
		begin
			rx_ack = rx_ack_lc;
			tx_addr = tx_addr_lc;
			tx_data = tx_data_lc;
			tx_req = tx_req_lc;
			tx_pend = tx_pend_lc;
		end
	end

	// Register file side
	always_comb
	begin
		if (hold)
		begin
			rf_load = 1'b0;
			rf_addr = '0;
			rf_wdata = '0;
		end
		else
		begin
			rf_load = rf_load_lc;
			rf_addr = rf_addr_lc;
			rf_wdata = rf_wdata_lc;
		end
	end

	// Memory side
	always_comb
	begin
		if (hold)
		begin
			mem_req = 1'b0;
			mem_write = 1'b0;
			mem_addr = '0;
			mem_wdata = '0;
		end
		else
		begin
			mem_req = mem_req_lc;
			mem_write = mem_write_lc;
			mem_addr = mem_addr_lc;
			mem_wdata = mem_wdata_lc;
		end
	end

endmodule

// ==== src/lc_fsm.sv ====
`timescale 1ns/10ps

module lc_fsm
	import lc_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [LC_ADDR_W-1:0]     rx_addr,
	input  logic [LC_DATA_W-1:0]     rx_data,
	input  logic                     rx_req,
	input  logic                     rx_pend,
	input  logic                     tx_ack,
	input  logic [LC_RF_DATA_W-1:0]  rf_rdata,
	input  logic [LC_DATA_W-1:0]     mem_rdata,
	input  logic [LC_ADDR_W-1:0]     cnt_addr,
	input  logic                     cnt_last,
	output logic                     rx_ack_lc,
	output logic [LC_ADDR_W-1:0]     tx_addr_lc,
	output logic [LC_DATA_W-1:0]     tx_data_lc,
	output logic                     tx_req_lc,
	output logic                     tx_pend_lc,
	output logic                     rf_load_lc,
	output logic [LC_ADDR_W-1:0]     rf_addr_lc,
	output logic [LC_RF_DATA_W-1:0]  rf_wdata_lc,
	output logic                     mem_req_lc,
	output logic                     mem_write_lc,
	output logic [LC_MEM_ADDR_W-1:0] mem_addr_lc,
	output logic [LC_DATA_W-1:0]     mem_wdata_lc,
	output logic                     cnt_load,
	output logic [LC_ADDR_W-1:0]     cnt_start,
	output logic [LC_CNT_W-1:0]      cnt_len,
	output logic                     cnt_step
);

	lc_state_e state;
	lc_state_e state_nxt;
	lc_rx_word_u rx_word_q;
	logic [LC_FUNC_W-1:0] func_q;
	logic rx_pend_q;
	logic in_msg;
	logic rd_pend;
	logic rd_mem;
	logic [LC_ADDR_W-1:0] tx_addr_q;
	logic [LC_DATA_W-1:0] tx_data_q;
	logic tx_pend_q;
	logic is_read;

	assign is_read = (func_q == FUNC_RF_RD) || (func_q == FUNC_MEM_RD);

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (rx_req)
					state_nxt = ST_DECODE;
			ST_DECODE:
				if (func_q == FUNC_RF_WR)
					state_nxt = ST_RF_WR;
				else if (func_q == FUNC_MEM_WR && in_msg)
					state_nxt = ST_MEM_WR;
				else
					state_nxt = ST_ACK;
			ST_RF_WR, ST_MEM_WR:
				state_nxt = ST_ACK;
			// Hold ack until the bus drops its request
			ST_ACK:
				if (!rx_req)
					state_nxt = rd_pend ? ST_RD_FETCH : ST_IDLE;
			ST_RD_FETCH:
				state_nxt = ST_RD_DATA;
			ST_RD_DATA:
				state_nxt = ST_TX;
			ST_TX:
				if (tx_ack)
					state_nxt = ST_TX_DONE;
			ST_TX_DONE:
				if (!tx_ack)
					state_nxt = tx_pend_q ? ST_RD_FETCH : ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= ST_IDLE;
			in_msg <= 1'b0;
			rd_pend <= 1'b0;
			rd_mem <= 1'b0;
			tx_pend_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == ST_DECODE)
			begin
				rd_pend <= is_read && (rx_word_q.rd_req.count != '0);
				rd_mem <= (func_q == FUNC_MEM_RD);
			end
			if (state == ST_ACK && !rx_req)
			begin
				in_msg <= rx_pend_q;
				rd_pend <= 1'b0;
			end
			// Last reply word goes out with pend low
			if (state == ST_RD_DATA)
				tx_pend_q <= !cnt_last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && rx_req)
		begin
			rx_word_q <= rx_data;
			func_q <= rx_addr[LC_FUNC_W-1:0];
			rx_pend_q <= rx_pend;
		end
		if (state == ST_DECODE && is_read)
			tx_addr_q <= rx_word_q.rd_req.reply_addr;
		if (state == ST_RD_DATA)
			tx_data_q <= rd_mem ? mem_rdata : {cnt_addr, rf_rdata};
	end

	// First word of a memory write carries the start address
	assign cnt_load = (state == ST_DECODE) &&
		(is_read || (func_q == FUNC_MEM_WR && !in_msg));
	assign cnt_start = (func_q == FUNC_MEM_WR) ? rx_word_q[LC_ADDR_W-1:0] :
		rx_word_q.rd_req.start;
	assign cnt_len = is_read ? rx_word_q.rd_req.count : '0;
	assign cnt_step = (state == ST_MEM_WR) || (state == ST_TX && tx_ack);

	assign rx_ack_lc = (state == ST_ACK);
	assign tx_req_lc = (state == ST_TX);
	assign tx_addr_lc = tx_addr_q;
	assign tx_data_lc = tx_data_q;
	assign tx_pend_lc = tx_pend_q;

	assign rf_load_lc = (state == ST_RF_WR);
	assign rf_addr_lc = (state == ST_RF_WR) ? rx_word_q.rf_wr.addr : cnt_addr;
	assign rf_wdata_lc = rx_word_q.rf_wr.data;

	assign mem_req_lc = (state == ST_MEM_WR) || (state == ST_RD_FETCH && rd_mem);
	assign mem_write_lc = (state == ST_MEM_WR);
	assign mem_addr_lc = cnt_addr[LC_MEM_ADDR_W-1:0];
	assign mem_wdata_lc = rx_word_q;

endmodule

// ==== src/layer_ctrl_top.sv ====
`timescale 1ns/10ps

module layer_ctrl_top
	import lc_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 lc_isolation,
	input  logic [LC_ADDR_W-1:0] rx_addr,
	input  logic [LC_DATA_W-1:0] rx_data,
	input  logic                 rx_req,
	input  logic                 rx_pend,
	output logic                 rx_ack,
	output logic [LC_ADDR_W-1:0] tx_addr,
	output logic [LC_DATA_W-1:0] tx_data,
	output logic                 tx_req,
	output logic                 tx_pend,
	input  logic                 tx_ack
);

	// Raw controller outputs ahead of the clamp
	logic rx_ack_lc;
	logic [LC_ADDR_W-1:0] tx_addr_lc;
	logic [LC_DATA_W-1:0] tx_data_lc;
	logic tx_req_lc;
	logic tx_pend_lc;
	logic rf_load_lc;
	logic [LC_ADDR_W-1:0] rf_addr_lc;
	logic [LC_RF_DATA_W-1:0] rf_wdata_lc;
	logic mem_req_lc;
	logic mem_write_lc;
	logic [LC_MEM_ADDR_W-1:0] mem_addr_lc;
	logic [LC_DATA_W-1:0] mem_wdata_lc;

	// Clamped register file and memory ports
	logic rf_load;
	logic [LC_ADDR_W-1:0] rf_addr;
	logic [LC_RF_DATA_W-1:0] rf_wdata;
	logic [LC_RF_DATA_W-1:0] rf_rdata;
	logic mem_req;
	logic mem_write;
	logic [LC_MEM_ADDR_W-1:0] mem_addr;
	logic [LC_DATA_W-1:0] mem_wdata;
	logic [LC_DATA_W-1:0] mem_rdata;

	// Burst counter
	logic cnt_load;
	logic [LC_ADDR_W-1:0] cnt_start;
	logic [LC_CNT_W-1:0] cnt_len;
	logic cnt_step;
	logic [LC_ADDR_W-1:0] cnt_addr;
	logic cnt_last;

	lc_fsm u_fsm (
		.clk          (clk),
		.arst_n       (arst_n),
		.rx_addr      (rx_addr),
		.rx_data      (rx_data),
		.rx_req       (rx_req),
		.rx_pend      (rx_pend),
		.tx_ack       (tx_ack),
		.rf_rdata     (rf_rdata),
		.mem_rdata    (mem_rdata),
		.cnt_addr     (cnt_addr),
		.cnt_last     (cnt_last),
		.rx_ack_lc    (rx_ack_lc),
		.tx_addr_lc   (tx_addr_lc),
		.tx_data_lc   (tx_data_lc),
		.tx_req_lc    (tx_req_lc),
		.tx_pend_lc   (tx_pend_lc),
		.rf_load_lc   (rf_load_lc),
		.rf_addr_lc   (rf_addr_lc),
		.rf_wdata_lc  (rf_wdata_lc),
		.mem_req_lc   (mem_req_lc),
		.mem_write_lc (mem_write_lc),
		.mem_addr_lc  (mem_addr_lc),
		.mem_wdata_lc (mem_wdata_lc),
		.cnt_load     (cnt_load),
		.cnt_start    (cnt_start),
		.cnt_len      (cnt_len),
		.cnt_step     (cnt_step)
	);

	lc_word_counter u_counter (
		.clk       (clk),
		.arst_n    (arst_n),
		.cnt_load  (cnt_load),
		.cnt_start (cnt_start),
		.cnt_len   (cnt_len),
		.cnt_step  (cnt_step),
		.cnt_addr  (cnt_addr),
		.cnt_last  (cnt_last)
	);

	lc_isolation u_isolation (
		.lc_isolation (lc_isolation),
		.rx_ack_lc    (rx_ack_lc),
		.tx_addr_lc   (tx_addr_lc),
		.tx_data_lc   (tx_data_lc),
		.tx_req_lc    (tx_req_lc),
		.tx_pend_lc   (tx_pend_lc),
		.rf_load_lc   (rf_load_lc),
		.rf_addr_lc   (rf_addr_lc),
		.rf_wdata_lc  (rf_wdata_lc),
		.mem_req_lc   (mem_req_lc),
		.mem_write_lc (mem_write_lc),
		.mem_addr_lc  (mem_addr_lc),
		.mem_wdata_lc (mem_wdata_lc),
		.rx_ack       (rx_ack),
		.tx_addr      (tx_addr),
		.tx_data      (tx_data),
		.tx_req       (tx_req),
		.tx_pend      (tx_pend),
		.rf_load      (rf_load),
		.rf_addr      (rf_addr),
		.rf_wdata     (rf_wdata),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

	lc_regfile u_regfile (
		.clk      (clk),
		.arst_n   (arst_n),
		.rf_load  (rf_load),
		.rf_addr  (rf_addr),
		.rf_wdata (rf_wdata),
		.rf_rdata (rf_rdata)
	);

	lc_mem u_mem (
		.clk       (clk),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== test/layer_ctrl_asserts.sv ====
`timescale 1ns/10ps

module layer_ctrl_asserts
	import lc_pkg::*;
(
	input logic                     clk,
	input logic                     arst_n,
	input logic                     lc_isolation,
	input logic                     rx_req,
	input logic                     rx_ack,
	input logic [LC_ADDR_W-1:0]     tx_addr,
	input logic [LC_DATA_W-1:0]     tx_data,
	input logic                     tx_req,
	input logic                     tx_pend,
	input logic                     tx_ack,
	input logic                     rf_load,
	input logic [LC_ADDR_W-1:0]     rf_addr,
	input logic [LC_RF_DATA_W-1:0]  rf_wdata,
	input logic                     mem_req,
	input logic                     mem_write,
	input logic [LC_MEM_ADDR_W-1:0] mem_addr,
	input logic [LC_DATA_W-1:0]     mem_wdata
);

	// Reply word stays up and steady until the bus takes it
	a_tx_hold: assert property (@(posedge clk)
		disable iff (!arst_n || lc_isolation == IO_HOLD)
		(tx_req && !tx_ack) |=>
			(tx_req && $stable(tx_addr) && $stable(tx_data) && $stable(tx_pend)))
		else $error("tx_req dropped or reply word changed before tx_ack");

	a_iso_clamp: assert property (@(posedge clk) disable iff (!arst_n)
		(lc_isolation == IO_HOLD) |->
			(!rx_ack && !tx_req && !tx_pend && tx_addr == '0 && tx_data == '0 &&
			!rf_load && rf_addr == '0 && rf_wdata == '0 &&
			!mem_req && !mem_write && mem_addr == '0 && mem_wdata == '0))
		else $error("Output not clamped to zero while isolated");

	// Ack is gone one cycle after the request falls
	a_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		!rx_req |=> !rx_ack)
		else $error("rx_ack high while rx_req is low");

endmodule

bind layer_ctrl_top layer_ctrl_asserts u_asserts (.*);

// ==== test/layer_ctrl_tb.sv ====
`timescale 1ns/10ps

module layer_ctrl_tb
	import lc_pkg::*;
();

	localparam string GOLDEN_PATH = "test/layer_ctrl_golden.txt";
	localparam int CYCLES_PER_LINE = 60;

	logic clk;
	logic arst_n;
	logic lc_isolation;
	logic [LC_ADDR_W-1:0] rx_addr;
	logic [LC_DATA_W-1:0] rx_data;
	logic rx_req;
	logic rx_pend;
	logic rx_ack;
	logic [LC_ADDR_W-1:0] tx_addr;
	logic [LC_DATA_W-1:0] tx_data;
	logic tx_req;
	logic tx_pend;
	logic tx_ack;

	integer seed;
	int cycle_count = 0;
	int cycle_limit = 0;

	layer_ctrl_top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	// Watchdog sized from the golden file length
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, golden file not finished", cycle_count);
			stop_with_failure();
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// All driving happens 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic present_word(input logic [LC_ADDR_W-1:0] addr,
		input logic [LC_DATA_W-1:0] data, input logic pend);
		next_cycle();
		rx_addr = addr;
		rx_data = data;
		rx_pend = pend;
		rx_req = 1'b1;
	endtask

	task automatic finish_handshake();
		while (rx_ack !== 1'b1)
			next_cycle();
		rx_req = 1'b0;
		while (rx_ack !== 1'b0)
			next_cycle();
	endtask

	task automatic expect_no_ack(input int cycles);
		repeat (cycles)
		begin
			next_cycle();
			check_value("rx_ack", 32'd0, 32'(rx_ack));
		end
	endtask

	task automatic expect_reply(input logic [31:0] addr, input logic [31:0] data,
		input logic [31:0] pend, input int extra_delay);
		int delay;
		while (tx_req !== 1'b1)
			next_cycle();
		check_value("tx_addr", addr, 32'(tx_addr));
		check_value("tx_data", data, tx_data);
		check_value("tx_pend", pend, 32'(tx_pend));
		delay = extra_delay + int'($unsigned($random(seed)) % 4);
		repeat (delay)
			next_cycle();
		tx_ack = 1'b1;
		while (tx_req !== 1'b0)
			next_cycle();
		tx_ack = 1'b0;
	endtask

	initial
	begin
		int fd;
		int code;
		int line_total;
		int kind;
		int f_n;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_pend;
		logic saw_end;
		string line;

		seed = 32'h621;
		arst_n = 1'b0;
		lc_isolation = 1'b0;
		rx_addr = '0;
		rx_data = '0;
		rx_req = 1'b0;
		rx_pend = 1'b0;
		tx_ack = 1'b0;
		saw_end = 1'b0;
		line_total = 0;

		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0)
		begin
			$display("Cannot open golden file %s", GOLDEN_PATH);
			stop_with_failure();
		end
		while ($fgets(line, fd) > 0)
			line_total++;
		$fclose(fd);
		cycle_limit = CYCLES_PER_LINE * line_total;

		repeat (4)
			@(posedge clk);
		#1;
		arst_n = 1'b1;

		fd = $fopen(GOLDEN_PATH, "r");
		while (!saw_end && $fgets(line, fd) > 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			code = $sscanf(line, "%d %h %h %h %d", kind, f_addr, f_data, f_pend, f_n);
			if (code != 5)
			begin
				$display("Malformed golden line: %s", line);
				stop_with_failure();
			end
			case (kind)
				0:
					saw_end = 1'b1;
				1:
				begin
					present_word(f_addr[LC_ADDR_W-1:0], f_data, f_pend[0]);
					finish_handshake();
				end
				2:
					expect_reply(f_addr, f_data, f_pend, f_n);
				3:
				begin
					next_cycle();
					lc_isolation = f_n[0];
				end
				4:
				begin
					present_word(f_addr[LC_ADDR_W-1:0], f_data, f_pend[0]);
					expect_no_ack(f_n);
				end
				5:
					finish_handshake();
				default:
				begin
					$display("Unknown line kind %0d in golden file", kind);
					stop_with_failure();
				end
			endcase
		end
		$fclose(fd);

		// No reply may be left over
		repeat (10)
			next_cycle();
		check_value("tx_req", 32'd0, 32'(tx_req));
		if (rx_req)
		begin
			$display("Golden file left a receive word without its acknowledge");
			stop_with_failure();
		end
		if (!saw_end)
		begin
			$display("Golden file ended before its end marker");
			stop_with_failure();
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== test/layer_ctrl_golden.txt ====
# kind addr data pend n  (1 send word, 2 expect reply with n extra ack cycles, 3 isolation = n)
# (4 present word, no rx_ack for n cycles, 5 finish presented word, 0 end of file)
1 50 02a1b2c3 1 0
1 50 0300ff00 1 0
1 50 04123456 1 0
1 50 05fedcba 0 0
1 51 02047c00 0 0
2 7c 02a1b2c3 1 0
2 7c 0300ff00 1 0
2 7c 04123456 1 0
2 7c 05fedcba 0 0
1 51 08023300 0 0
2 33 08000000 1 0
2 33 09000000 0 0
1 52 00000010 1 0
1 52 deadbeef 1 0
1 52 0badf00d 1 0
1 52 13579bdf 0 0
1 53 10039a00 0 0
2 9a deadbeef 1 0
2 9a 0badf00d 1 0
2 9a 13579bdf 0 0
3 00 00000000 0 1
4 50 02555555 0 20
3 00 00000000 0 0
5 00 00000000 0 0
1 51 02014400 0 0
2 44 02a1b2c3 0 0
1 5a 02047700 0 0
1 51 0204ee00 0 0
2 ee 02a1b2c3 1 25
2 ee 0300ff00 1 30
2 ee 04123456 1 25
2 ee 05fedcba 0 30
0 00 00000000 0 0

// ==== flist.f ====
src/lc_pkg.sv
src/lc_word_counter.sv
src/lc_regfile.sv
src/lc_mem.sv
src/lc_isolation.sv
src/lc_fsm.sv
src/layer_ctrl_top.sv
test/layer_ctrl_asserts.sv
test/layer_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module layer_ctrl_tb -f flist.f -o layer_ctrl_sim \
	&& ./obj_dir/layer_ctrl_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation completed successfully$" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
